/* compile.f */
+incdir+verification
rtl/lspPkg.sv
rtl/gridPointsMem.sv
rtl/lspCoefLoader.sv
rtl/chebyshevEval.sv
rtl/rootSearchCtrl.sv
rtl/lspRootOut.sv
rtl/lspRootSearch.sv
verification/lspRootSearchTb.sv

/* rtl/chebyshevEval.sv */
`timescale 1ns/1ps

module chebyshevEval (
	input  logic clk,
	input  logic rstN,
	input  logic evalStart,
	input  lspPkg::cosT x,
	input  lspPkg::lspPolyT poly,
	output lspPkg::accT evalResult,
	output logic evalDone
);

	// Operands held for the whole evaluation
	lspPkg::cosT xReg;
	lspPkg::lspPolyT polyReg;
	// Recursion terms
	lspPkg::accT b1;
	lspPkg::accT b2;
	lspPkg::accT b0;
	// Sequencer
	logic running;
	logic [2:0] stepCnt;
	logic lastStep;
	// Shared multiplier and its uses
	lspPkg::accT prod;
	lspPkg::accT dblTerm;
	lspPkg::accT finalVal;
	lspPkg::coefT cSel;

	////////////////////////////////////////
	// Datapath
	////////////////////////////////////////

	// One multiplier, x * b1, 32-bit wrap
	assign prod = lspPkg::accT'(xReg) * b1;
	// 2*x*b1 in Q15 back to Q12
	assign dblTerm = (prod <<< 1) >>> 15;

	// Coefficient for the middle steps
	always_comb begin
		case (stepCnt)
			3'd1: cSel = polyReg.c2;
			3'd2: cSel = polyReg.c3;
			default: cSel = polyReg.c4;
		endcase
	end

	assign b0 = dblTerm - b2 + lspPkg::accT'(cSel);
	// Last term uses x*b1 once and half of c5
	assign finalVal = (prod >>> 15) - b2 + (lspPkg::accT'(polyReg.c5) >>> 1);

	// Step evalLatency-1 produces the result
	assign lastStep = (stepCnt == 3'(lspPkg::evalLatency - 1));

	////////////////////////////////////////
	// Control
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rstN) begin
			running <= 1'b0;
			stepCnt <= '0;
			evalDone <= 1'b0;
		end else begin
			evalDone <= 1'b0;
			if (evalStart) begin
				// Init happens on the capture edge
				running <= 1'b1;
				stepCnt <= 3'd1;
			end else if (running) begin
				if (lastStep) begin
					running <= 1'b0;
					stepCnt <= '0;
					evalDone <= 1'b1;
				end else begin
					stepCnt <= stepCnt + 3'd1;
				end
			end
		end
	end

	// Operand capture and recursion update
	always_ff @(posedge clk) begin
		if (evalStart) begin
			xReg <= x;
			polyReg <= poly;
			b2 <= lspPkg::accT'(lspPkg::qOne);
			b1 <= (lspPkg::accT'(x) >>> 2) + lspPkg::accT'(poly.c1);
		end else if (running) begin
			if (lastStep) begin
				evalResult <= finalVal;
			end else begin
				b2 <= b1;
				b1 <= b0;
			end
		end
	end

endmodule

/* rtl/gridPointsMem.sv */
`timescale 1ns/1ps

module gridPointsMem (
	input  lspPkg::gridIdxT gridIdx,
	output lspPkg::cosT cosVal
);

	// Cosine grid, cos(pi*i/60) in Q15
	// Second half mirrors the first with negated values
	always_comb begin
		cosVal = '0;
		case (gridIdx)
			6'd0: cosVal = 16'sd32760;
			6'd1: cosVal = 16'sd32723;
			6'd2: cosVal = 16'sd32588;
			6'd3: cosVal = 16'sd32364;
			6'd4: cosVal = 16'sd32051;
			6'd5: cosVal = 16'sd31651;
			6'd6: cosVal = 16'sd31164;
			6'd7: cosVal = 16'sd30591;
			6'd8: cosVal = 16'sd29935;
			6'd9: cosVal = 16'sd29196;
			6'd10: cosVal = 16'sd28377;
			6'd11: cosVal = 16'sd27481;
			6'd12: cosVal = 16'sd26509;
			6'd13: cosVal = 16'sd25465;
			6'd14: cosVal = 16'sd24351;
			6'd15: cosVal = 16'sd23170;
			6'd16: cosVal = 16'sd21926;
			6'd17: cosVal = 16'sd20621;
			6'd18: cosVal = 16'sd19260;
			6'd19: cosVal = 16'sd17846;
			6'd20: cosVal = 16'sd16384;
			6'd21: cosVal = 16'sd14876;
			6'd22: cosVal = 16'sd13327;
			6'd23: cosVal = 16'sd11743;
			6'd24: cosVal = 16'sd10125;
			6'd25: cosVal = 16'sd8480;
			6'd26: cosVal = 16'sd6812;
			6'd27: cosVal = 16'sd5126;
			6'd28: cosVal = 16'sd3425;
			6'd29: cosVal = 16'sd1714;
			// Quarter turn
			6'd30: cosVal = 16'sd0;
			6'd31: cosVal = -16'sd1714;
			6'd32: cosVal = -16'sd3425;
			6'd33: cosVal = -16'sd5126;
			6'd34: cosVal = -16'sd6812;
			6'd35: cosVal = -16'sd8480;
			6'd36: cosVal = -16'sd10125;
			6'd37: cosVal = -16'sd11743;
			6'd38: cosVal = -16'sd13327;
			6'd39: cosVal = -16'sd14876;
			6'd40: cosVal = -16'sd16384;
			6'd41: cosVal = -16'sd17846;
			6'd42: cosVal = -16'sd19260;
			6'd43: cosVal = -16'sd20621;
			6'd44: cosVal = -16'sd21926;
			6'd45: cosVal = -16'sd23170;
			6'd46: cosVal = -16'sd24351;
			6'd47: cosVal = -16'sd25465;
			6'd48: cosVal = -16'sd26509;
			6'd49: cosVal = -16'sd27481;
			6'd50: cosVal = -16'sd28377;
			6'd51: cosVal = -16'sd29196;
			6'd52: cosVal = -16'sd29935;
			6'd53: cosVal = -16'sd30591;
			6'd54: cosVal = -16'sd31164;
			6'd55: cosVal = -16'sd31651;
			6'd56: cosVal = -16'sd32051;
			6'd57: cosVal = -16'sd32364;
			6'd58: cosVal = -16'sd32588;
			6'd59: cosVal = -16'sd32723;
			6'd60: cosVal = -16'sd32760;
			// Off the end of the grid
			default: cosVal = '0;
		endcase
	end

endmodule

/* rtl/lspCoefLoader.sv */
`timescale 1ns/1ps

module lspCoefLoader (
	input  logic clk,
	input  logic rstN,
	input  logic coefWrite,
	input  logic coefPoly,
	input  lspPkg::coefIdxT coefIdx,
	input  lspPkg::coefT coefData,
	output lspPkg::lspPolySetT polys
);

	// Replace one slot of a polynomial
	// Slot numbers outside 1 to 5 leave it untouched
	function automatic lspPkg::lspPolyT setCoef(
		input lspPkg::lspPolyT cur,
		input lspPkg::coefIdxT idx,
		input lspPkg::coefT val
	);
		lspPkg::lspPolyT upd;
		upd = cur;
		case (idx)
			3'd1: upd.c1 = val;
			3'd2: upd.c2 = val;
			3'd3: upd.c3 = val;
			3'd4: upd.c4 = val;
			3'd5: upd.c5 = val;
			default: upd = cur;
		endcase
		return upd;
	endfunction

	////////////////////////////////////////
	// Coefficient register file
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rstN) begin
			polys <= '0;
		end else if (coefWrite) begin
			// coefPoly picks F2 when high
			if (coefPoly) begin
				polys.f2 <= setCoef(polys.f2, coefIdx, coefData);
			end else begin
				polys.f1 <= setCoef(polys.f1, coefIdx, coefData);
			end
		end
	end

endmodule

/* rtl/lspPkg.sv */
package lspPkg;

	////////////////////////////////////////
	// Fixed sizes from the G.729 search
	////////////////////////////////////////

	// Last index of the cosine grid
	localparam int gridLast = 60;
	// Ten LSPs per frame
	localparam int maxRoots = 10;
	// 1.0 in Q12
	localparam int qOne = 4096;
	// Cycles from evalStart to evalDone
	localparam int evalLatency = 5;

	////////////////////////////////////////
	// Scalar types
	////////////////////////////////////////

	// Grid position, 0 to 60
	typedef logic [5:0] gridIdxT;
	// Cosine grid value, Q15
	typedef logic signed [15:0] cosT;
	// Polynomial coefficient, Q12
	typedef logic signed [15:0] coefT;
	// Recursion intermediates and results
	typedef logic signed [31:0] accT;
	// Coefficient slot, 1 to 5
	typedef logic [2:0] coefIdxT;
	// Roots found so far
	typedef logic [3:0] rootCountT;

	////////////////////////////////////////
	// Bundles
	////////////////////////////////////////

	// One polynomial, c1 in the top bits
	typedef struct packed {
		coefT c1;
		coefT c2;
		coefT c3;
		coefT c4;
		coefT c5;
	} lspPolyT;

	// Both polynomials
	typedef struct packed {
		lspPolyT f1;
		lspPolyT f2;
	} lspPolySetT;

	// One reported root
	typedef struct packed {
		logic polySel;
		gridIdxT gridIdx;
		cosT cosVal;
	} rootInfoT;

	// Search controller states
	typedef enum logic [2:0] {
		idle,
		evalLow,
		evalHigh,
		check,
		finish
	} searchStateT;

endpackage

/* rtl/lspRootOut.sv */
`timescale 1ns/1ps

module lspRootOut (
	input  logic clk,
	input  logic rstN,
	input  logic start,
	input  logic rootFound,
	input  lspPkg::rootInfoT root,
	input  logic searchEnd,
	input  lspPkg::rootCountT rdIdx,
	output logic rootValid,
	output lspPkg::rootInfoT rootInfo,
	output logic rootsFull,
	output logic searchDone,
	output lspPkg::rootCountT rootCount,
	output lspPkg::rootInfoT rdData
);

	// Ten result slots, one per LSP
	lspPkg::rootInfoT resultMem [lspPkg::maxRoots];
	// Tracks a running search so a stray start does not clear the count
	logic searching;

	assign rootsFull = (rootCount == lspPkg::rootCountT'(lspPkg::maxRoots));
	// Readback, zero past the last slot
	assign rdData = (rdIdx < lspPkg::rootCountT'(lspPkg::maxRoots)) ? resultMem[rdIdx] : '0;

	////////////////////////////////////////
	// Counter and strobes
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rstN) begin
			rootValid <= 1'b0;
			searchDone <= 1'b0;
			rootCount <= '0;
			searching <= 1'b0;
		end else begin
			rootValid <= rootFound;
			searchDone <= searchEnd;
			if (start && !searching) begin
				searching <= 1'b1;
				rootCount <= '0;
			end else begin
				if (rootFound && !rootsFull) begin
					rootCount <= rootCount + 4'd1;
				end
				if (searchEnd) begin
					searching <= 1'b0;
				end
			end
		end
	end

	// Streamed copy and stored copy
	always_ff @(posedge clk) begin
		if (rootFound) begin
			rootInfo <= root;
		end
		if (rootFound && !rootsFull) begin
			resultMem[rootCount] <= root;
		end
	end

endmodule

/* rtl/lspRootSearch.sv */
`timescale 1ns/1ps

module lspRootSearch (
	input  logic clk,
	input  logic rstN,
	input  logic start,
	input  logic coefWrite,
	input  logic coefPoly,
	input  lspPkg::coefIdxT coefIdx,
	input  lspPkg::coefT coefData,
	input  lspPkg::rootCountT rdIdx,
	output logic busy,
	output logic rootValid,
	output lspPkg::rootInfoT rootInfo,
	output logic searchDone,
	output lspPkg::rootCountT rootCount,
	output lspPkg::rootInfoT rdData
);

	// Loader to controller
	lspPkg::lspPolySetT polys;
	// Controller to ROM and evaluator
	lspPkg::gridIdxT gridIdx;
	lspPkg::cosT cosVal;
	logic evalStart;
	lspPkg::cosT evalX;
	lspPkg::lspPolyT evalPoly;
	lspPkg::accT evalResult;
	logic evalDone;
	// Controller to output side
	logic rootFound;
	lspPkg::rootInfoT root;
	logic searchEnd;
	logic rootsFull;

	////////////////////////////////////////
	// Input side
	////////////////////////////////////////

	lspCoefLoader uLoader (
		.clk(clk),
		.rstN(rstN),
		.coefWrite(coefWrite),
		.coefPoly(coefPoly),
		.coefIdx(coefIdx),
		.coefData(coefData),
		.polys(polys)
	);

	////////////////////////////////////////
	// Search and evaluation
	////////////////////////////////////////

	rootSearchCtrl uCtrl (
		.clk(clk),
		.rstN(rstN),
		.start(start),
		.polys(polys),
		.cosVal(cosVal),
		.evalResult(evalResult),
		.evalDone(evalDone),
		.rootsFull(rootsFull),
		.gridIdx(gridIdx),
		.evalStart(evalStart),
		.evalX(evalX),
		.evalPoly(evalPoly),
		.rootFound(rootFound),
		.root(root),
		.searchEnd(searchEnd),
		.busy(busy)
	);

	gridPointsMem uGrid (
		.gridIdx(gridIdx),
		.cosVal(cosVal)
	);

	chebyshevEval uEval (
		.clk(clk),
		.rstN(rstN),
		.evalStart(evalStart),
		.x(evalX),
		.poly(evalPoly),
		.evalResult(evalResult),
		.evalDone(evalDone)
	);

	////////////////////////////////////////
	// Output side
	////////////////////////////////////////

	lspRootOut uOut (
		.clk(clk),
		.rstN(rstN),
		.start(start),
		.rootFound(rootFound),
		.root(root),
		.searchEnd(searchEnd),
		.rdIdx(rdIdx),
		.rootValid(rootValid),
		.rootInfo(rootInfo),
		.rootsFull(rootsFull),
		.searchDone(searchDone),
		.rootCount(rootCount),
		.rdData(rdData)
	);

endmodule

/* rtl/rootSearchCtrl.sv */
`timescale 1ns/1ps

module rootSearchCtrl (
	input  logic clk,
	input  logic rstN,
	input  logic start,
	input  lspPkg::lspPolySetT polys,
	input  lspPkg::cosT cosVal,
	input  lspPkg::accT evalResult,
	input  logic evalDone,
	input  logic rootsFull,
	output lspPkg::gridIdxT gridIdx,
	output logic evalStart,
	output lspPkg::cosT evalX,
	output lspPkg::lspPolyT evalPoly,
	output logic rootFound,
	output lspPkg::rootInfoT root,
	output logic searchEnd,
	output logic busy
);

	lspPkg::searchStateT state;
	// Upper grid index of the interval under test
	lspPkg::gridIdxT j;
	// 0 for F1, 1 for F2
	logic curPoly;
	// Polynomial values at both interval ends
	lspPkg::accT yLow;
	lspPkg::accT yHigh;
	logic signChange;

	// Evaluator sees the ROM output and the selected set directly
	assign evalX = cosVal;
	assign evalPoly = curPoly ? polys.f2 : polys.f1;

	assign signChange = yLow[31] ^ yHigh[31];
	assign searchEnd = (state == lspPkg::finish);
	// Drops in the cycle searchDone shows
	assign busy = (state != lspPkg::idle);

	////////////////////////////////////////
	// Grid walk
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= lspPkg::idle;
			j <= '0;
			curPoly <= 1'b0;
			gridIdx <= '0;
			evalStart <= 1'b0;
			rootFound <= 1'b0;
		end else begin
			// Single-cycle strobes
			evalStart <= 1'b0;
			rootFound <= 1'b0;
			case (state)
				lspPkg::idle: begin
					if (start) begin
						// F1 at grid[0] first
						curPoly <= 1'b0;
						j <= 6'd1;
						gridIdx <= '0;
						evalStart <= 1'b1;
						state <= lspPkg::evalLow;
					end
				end
				lspPkg::evalLow: begin
					if (evalDone) begin
						yLow <= evalResult;
						// Ten roots stored, stop here
						if (rootsFull) begin
							state <= lspPkg::finish;
						end else begin
							gridIdx <= j;
							evalStart <= 1'b1;
							state <= lspPkg::evalHigh;
						end
					end
				end
				lspPkg::evalHigh: begin
					if (evalDone) begin
						yHigh <= evalResult;
						// Point ROM at the lower end for a possible root
						gridIdx <= j - 6'd1;
						state <= lspPkg::check;
					end
				end
				lspPkg::check: begin
					if (signChange) begin
						// Root at j-1, ROM already shows its cosine
						rootFound <= 1'b1;
						root <= '{polySel: curPoly, gridIdx: gridIdx, cosVal: cosVal};
						// Other polynomial, re-evaluate grid[j-1]
						curPoly <= ~curPoly;
						evalStart <= 1'b1;
						state <= lspPkg::evalLow;
					end else if (j == lspPkg::gridIdxT'(lspPkg::gridLast)) begin
						// Grid exhausted
						state <= lspPkg::finish;
					end else begin
						yLow <= yHigh;
						j <= j + 6'd1;
						gridIdx <= j + 6'd1;
						evalStart <= 1'b1;
						state <= lspPkg::evalHigh;
					end
				end
				lspPkg::finish: begin
					state <= lspPkg::idle;
				end
				default: begin
					state <= lspPkg::idle;
				end
			endcase
		end
	end

endmodule

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module lspRootSearchTb -f compile.f || exit 1
out=$(./obj_dir/VlspRootSearchTb 2>&1)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "Regression passed" && exit 0 || exit 1

/* verification/lspModel.svh */
`ifndef lspModelSvh
`define lspModelSvh

////////////////////////////////////////
// Reference cosine grid
////////////////////////////////////////

// First half of the grid, cos(pi*i/60) in Q15
localparam int cosHalf[31] = '{
	32760, 32723, 32588, 32364, 32051, 31651, 31164, 30591,
	29935, 29196, 28377, 27481, 26509, 25465, 24351, 23170,
	21926, 20621, 19260, 17846, 16384, 14876, 13327, 11743,
	10125, 8480, 6812, 5126, 3425, 1714, 0
};

// Roots expected from the current search, in order
lspPkg::rootInfoT modelRoots[$];
// Random source for the coefficient sets
logic [31:0] lfsrState = 32'h94894872;

// Second half is the negated mirror of the first
function automatic int gridCos(int idx);
	if (idx < 0 || idx > lspPkg::gridLast) begin
		return 0;
	end
	if (idx <= 30) begin
		return cosHalf[5'(idx)];
	end
	return -cosHalf[5'(lspPkg::gridLast - idx)];
endfunction

////////////////////////////////////////
// Chebyshev rule
////////////////////////////////////////

// One middle term, 2*x*b1 back to Q12
function automatic int chebStep(int x, int b1, int b2, int c);
	return ((2 * x * b1) >>> 15) - b2 + c;
endfunction

function automatic int chebEval(int x, lspPkg::lspPolyT p);
	int b0;
	int b1;
	int b2;
	b2 = lspPkg::qOne;
	// Q15 x shifted by 2 is 2x in Q12
	b1 = (x >>> 2) + int'(p.c1);
	b0 = chebStep(x, b1, b2, int'(p.c2));
	b2 = b1;
	b1 = b0;
	b0 = chebStep(x, b1, b2, int'(p.c3));
	b2 = b1;
	b1 = b0;
	b0 = chebStep(x, b1, b2, int'(p.c4));
	b2 = b1;
	b1 = b0;
	return ((x * b1) >>> 15) - b2 + (int'(p.c5) >>> 1);
endfunction

////////////////////////////////////////
// Grid walk with alternation
////////////////////////////////////////

function automatic void searchRoots(lspPkg::lspPolySetT ps);
	int j;
	int yLow;
	int yHigh;
	logic sel;
	lspPkg::rootInfoT r;
	modelRoots.delete();
	sel = 1'b0;
	j = 1;
	yLow = chebEval(gridCos(0), ps.f1);
	while (j <= lspPkg::gridLast && modelRoots.size() < lspPkg::maxRoots) begin
		yHigh = chebEval(gridCos(j), sel ? ps.f2 : ps.f1);
		if ((yLow < 0) != (yHigh < 0)) begin
			r.polySel = sel;
			r.gridIdx = lspPkg::gridIdxT'(j - 1);
			r.cosVal = lspPkg::cosT'(gridCos(j - 1));
			modelRoots.push_back(r);
			// Other polynomial restarts at the lower end, same j
			sel = ~sel;
			yLow = chebEval(gridCos(j - 1), sel ? ps.f2 : ps.f1);
		end else begin
			yLow = yHigh;
			j++;
		end
	end
endfunction

////////////////////////////////////////
// Galois LFSR
////////////////////////////////////////

// Right-shift form, taps 32 31 29 1
function automatic logic [31:0] lfsrNext(logic [31:0] s);
	return s[0] ? ((s >> 1) ^ 32'hD0000001) : (s >> 1);
endfunction

// One step per bit, first bit ends up on top
function automatic logic [31:0] takeBits(int n);
	logic [31:0] bits;
	bits = '0;
	for (int k = 0; k < n; k++) begin
		bits = {bits[30:0], lfsrState[0]};
		lfsrState = lfsrNext(lfsrState);
	end
	return bits;
endfunction

`endif

/* verification/lspRootSearchTb.sv */
`timescale 1ns/1ps

module lspRootSearchTb;

	// Perturbed sets plus two hand-built ones
	localparam int randomSearches = 8;
	localparam int searchCount = randomSearches + 2;
	// Per search, 6*(2*61+10) evaluations of 6 cycles at 40 ns
	localparam int searchBudgetNs =
		6 * (2 * (lspPkg::gridLast + 1) + lspPkg::maxRoots) * 6 * 40;

	logic clk = 1'b0;
	logic rstN;
	logic start;
	logic coefWrite;
	logic coefPoly;
	lspPkg::coefIdxT coefIdx;
	lspPkg::coefT coefData;
	lspPkg::rootCountT rdIdx;
	logic busy;
	logic rootValid;
	lspPkg::rootInfoT rootInfo;
	logic searchDone;
	lspPkg::rootCountT rootCount;
	lspPkg::rootInfoT rdData;

	// Roots seen on the stream in this search
	int rootsSeen = 0;

	`include "lspModel.svh"

	lspRootSearch dut (
		.clk(clk),
		.rstN(rstN),
		.start(start),
		.coefWrite(coefWrite),
		.coefPoly(coefPoly),
		.coefIdx(coefIdx),
		.coefData(coefData),
		.rdIdx(rdIdx),
		.busy(busy),
		.rootValid(rootValid),
		.rootInfo(rootInfo),
		.searchDone(searchDone),
		.rootCount(rootCount),
		.rdData(rdData)
	);

	// 40 ns period
	always #20 clk = ~clk;

	////////////////////////////////////////
	// Failure reporting
	////////////////////////////////////////

	task automatic abortRun();
		$display("Regression failed");
		$fatal(1);
	endtask

	task automatic stopOnError(string what);
		$display("Error at %0t: %s", $time, what);
		abortRun();
	endtask

	task automatic reportMismatch(string sigName, int got, int want);
		$display("Mismatch at %0t: %s is %0d, expected %0d", $time, sigName, got, want);
		abortRun();
	endtask

	task automatic checkRoot(string where, lspPkg::rootInfoT got, lspPkg::rootInfoT want);
		assert (got.polySel == want.polySel)
			else reportMismatch({where, ".polySel"}, int'(got.polySel), int'(want.polySel));
		assert (got.gridIdx == want.gridIdx)
			else reportMismatch({where, ".gridIdx"}, int'(got.gridIdx), int'(want.gridIdx));
		assert (got.cosVal == want.cosVal)
			else reportMismatch({where, ".cosVal"}, int'(got.cosVal), int'(want.cosVal));
	endtask

	////////////////////////////////////////
	// Concurrent checks
	////////////////////////////////////////

	// Accepted start shows as busy one cycle later
	assert property (@(posedge clk) disable iff (!rstN) (start && !busy) |=> busy)
		else stopOnError("busy did not rise in the cycle after start");
	// Controller already idle when done shows
	assert property (@(posedge clk) disable iff (!rstN) searchDone |-> !busy)
		else stopOnError("busy still high in the searchDone cycle");
	assert property (@(posedge clk) disable iff (!rstN)
		rootCount <= lspPkg::rootCountT'(lspPkg::maxRoots))
		else stopOnError("rootCount went past the ten-root limit");
	// A root pulse and the done pulse never share a cycle
	assert property (@(posedge clk) disable iff (!rstN) !(rootValid && searchDone))
		else stopOnError("rootValid and searchDone high together");

	// Stream monitor, sampled mid-cycle
	always @(negedge clk) begin
		if (rstN && rootValid) begin
			if (rootsSeen < modelRoots.size()) begin
				// Cosine compared against the reference grid table
				checkRoot("rootInfo", rootInfo, modelRoots[rootsSeen]);
				rootsSeen++;
			end else begin
				stopOnError("rootValid pulse with no root left in the expected list");
			end
		end
	end

	////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////

	// Inputs change 2 ns after the rising edge
	task automatic stepCycle();
		@(posedge clk);
		#2;
	endtask

	task automatic writeCoef(logic poly, int idx, lspPkg::coefT val);
		stepCycle();
		coefWrite = 1'b1;
		coefPoly = poly;
		coefIdx = lspPkg::coefIdxT'(idx);
		coefData = val;
		stepCycle();
		coefWrite = 1'b0;
	endtask

	task automatic loadPolys(lspPkg::lspPolySetT ps);
		writeCoef(1'b0, 1, ps.f1.c1);
		writeCoef(1'b0, 2, ps.f1.c2);
		writeCoef(1'b0, 3, ps.f1.c3);
		writeCoef(1'b0, 4, ps.f1.c4);
		writeCoef(1'b0, 5, ps.f1.c5);
		writeCoef(1'b1, 1, ps.f2.c1);
		writeCoef(1'b1, 2, ps.f2.c2);
		writeCoef(1'b1, 3, ps.f2.c3);
		writeCoef(1'b1, 4, ps.f2.c4);
		writeCoef(1'b1, 5, ps.f2.c5);
	endtask

	// Base value plus a 13-bit signed offset when perturbed
	function automatic lspPkg::coefT nextCoef(int base, logic perturb);
		logic [31:0] raw;
		logic signed [12:0] delta;
		if (!perturb) begin
			return lspPkg::coefT'(base);
		end
		raw = takeBits(13);
		delta = raw[12:0];
		return lspPkg::coefT'(base + int'(delta));
	endfunction

	// Flat spectrum has F1 = -1,+1,-1,+1,-1 and F2 all +1
	function automatic lspPkg::lspPolyT makePoly(logic alternate, logic perturb);
		lspPkg::lspPolyT p;
		int base;
		base = alternate ? -lspPkg::qOne : lspPkg::qOne;
		p.c1 = nextCoef(base, perturb);
		base = alternate ? -base : base;
		p.c2 = nextCoef(base, perturb);
		base = alternate ? -base : base;
		p.c3 = nextCoef(base, perturb);
		base = alternate ? -base : base;
		p.c4 = nextCoef(base, perturb);
		base = alternate ? -base : base;
		p.c5 = nextCoef(base, perturb);
		return p;
	endfunction

	////////////////////////////////////////
	// One full search with checks
	////////////////////////////////////////

	// wantCount below zero means any count
	task automatic runSearch(lspPkg::lspPolySetT ps, int wantCount);
		lspPkg::rootInfoT got;
		loadPolys(ps);
		searchRoots(ps);
		rootsSeen = 0;
		if (wantCount >= 0) begin
			assert (modelRoots.size() == wantCount)
				else stopOnError("hand-built set does not give its intended root count");
		end
		stepCycle();
		start = 1'b1;
		stepCycle();
		start = 1'b0;
		assert (busy) else stopOnError("busy low in the cycle after start");
		do @(negedge clk); while (!searchDone);
		assert (int'(rootCount) == modelRoots.size())
			else reportMismatch("rootCount", int'(rootCount), modelRoots.size());
		assert (rootsSeen == modelRoots.size())
			else reportMismatch("rootValid pulses", rootsSeen, modelRoots.size());
		assert (!busy) else stopOnError("busy still high at searchDone");
		// Result memory holds the expected roots in stream order
		for (int i = 0; i < modelRoots.size(); i++) begin
			stepCycle();
			rdIdx = lspPkg::rootCountT'(i);
			@(negedge clk);
			got = rdData;
			checkRoot("rdData", got, modelRoots[i]);
		end
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial begin
		lspPkg::lspPolySetT polySet;
		rstN = 1'b0;
		start = 1'b0;
		coefWrite = 1'b0;
		coefPoly = 1'b0;
		coefIdx = '0;
		coefData = '0;
		rdIdx = '0;
		repeat (2) @(posedge clk);
		#2;
		rstN = 1'b1;
		@(negedge clk);
		// Idle outputs out of reset
		assert (!busy) else reportMismatch("busy", int'(busy), 0);
		assert (!rootValid) else reportMismatch("rootValid", int'(rootValid), 0);
		assert (!searchDone) else reportMismatch("searchDone", int'(searchDone), 0);
		assert (rootCount == '0) else reportMismatch("rootCount", int'(rootCount), 0);
		// Random sets around a flat spectrum
		for (int t = 0; t < randomSearches; t++) begin
			polySet.f1 = makePoly(1'b1, 1'b1);
			polySet.f2 = makePoly(1'b0, 1'b1);
			runSearch(polySet, -1);
		end
		// Interleaved roots, stops on the tenth
		polySet.f1 = makePoly(1'b1, 1'b0);
		polySet.f2 = makePoly(1'b0, 1'b0);
		runSearch(polySet, lspPkg::maxRoots);
		// Offset of about 4 keeps both polynomials positive
		polySet = '0;
		polySet.f1.c5 = 16'sd32767;
		polySet.f2.c5 = 16'sd32767;
		runSearch(polySet, 0);
		$display("Regression passed");
		$finish;
	end

	// Watchdog
	initial begin
		#(searchCount * searchBudgetNs);
		stopOnError("Watchdog expired before all searches completed");
	end

endmodule
